// ==== sources.f ====
+incdir+include
hw/ptw_pkg.sv
hw/ptw_pte_check.sv
hw/ptw_req_ctx.sv
hw/ptw_walk_ctrl.sv
hw/ptw_top.sv
bench/ptw_mem_model.sv
bench/ptw_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the page table walker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module ptw_tb \
    -o ptw_sim

./obj_dir/ptw_sim

// ==== bench/ptw_tb.sv ====
`timescale 1ns/1ns
`include "ptw_params.svh"

module ptw_tb;
    import ptw_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_WALKS  = 17;

    logic   clk_i;
    logic   rst_ni;
    logic   flush_i;
    logic   en_instr;
    logic   en_data;
    logic   lsu_is_store;
    logic   mxr;
    asid_t  asid;
    ppn_t   satp_ppn;
    logic   itlb_access;
    logic   itlb_hit;
    vaddr_t itlb_vaddr;
    logic   dtlb_access;
    logic   dtlb_hit;
    vaddr_t dtlb_vaddr;
    logic   mem_gnt;
    logic   mem_rvalid;
    pte_t   mem_rdata;
    logic   mem_req_o;
    paddr_t mem_addr_o;
    logic   ptw_active_o;
    logic   walking_instr_o;
    logic   ptw_error_o;
    logic   itlb_update_valid_o;
    logic   dtlb_update_valid_o;
    vpn_t   update_vpn_o;
    asid_t  update_asid_o;
    logic   update_is_2m_o;
    logic   update_is_1g_o;
    pte_t   update_content_o;
    vaddr_t update_vaddr_o;
    logic   itlb_miss_o;
    logic   dtlb_miss_o;

    // PTE pointers the reference walk reads, in order
    paddr_t exp_addrs [$];

    ptw_top dut0 (
        .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
        .enable_translation_i(en_instr), .en_ld_st_translation_i(en_data),
        .lsu_is_store_i(lsu_is_store), .mxr_i(mxr), .asid_i(asid), .satp_ppn_i(satp_ppn),
        .itlb_access_i(itlb_access), .itlb_hit_i(itlb_hit), .itlb_vaddr_i(itlb_vaddr),
        .dtlb_access_i(dtlb_access), .dtlb_hit_i(dtlb_hit), .dtlb_vaddr_i(dtlb_vaddr),
        .mem_gnt_i(mem_gnt), .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata),
        .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .ptw_active_o(ptw_active_o),
        .walking_instr_o(walking_instr_o), .ptw_error_o(ptw_error_o),
        .itlb_update_valid_o(itlb_update_valid_o), .dtlb_update_valid_o(dtlb_update_valid_o),
        .update_vpn_o(update_vpn_o), .update_asid_o(update_asid_o),
        .update_is_2m_o(update_is_2m_o), .update_is_1g_o(update_is_1g_o),
        .update_content_o(update_content_o), .update_vaddr_o(update_vaddr_o),
        .itlb_miss_o(itlb_miss_o), .dtlb_miss_o(dtlb_miss_o)
    );

    ptw_mem_model mem0 (
        .clk_i(clk_i), .rst_ni(rst_ni), .req_i(mem_req_o), .addr_i(mem_addr_o),
        .gnt_o(mem_gnt), .rvalid_o(mem_rvalid), .rdata_o(mem_rdata)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // an error and an update never end the same walk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ptw_error_o && (itlb_update_valid_o || dtlb_update_valid_o)))
    else begin
        $display("error and update pulse seen in the same cycle");
        $display("Simulation failed");
        $fatal(1, "walk ended twice");
    end

    // watchdog, 40 cycles per walk plus reset
    initial begin
        #(40 * NUM_WALKS * CLK_PERIOD + 10 * CLK_PERIOD);
        $display("Simulation failed");
        $fatal(1, "walk did not finish");
    end

    task automatic check_value(input string test, input string field,
                               input logic [63:0] exp_v, input logic [63:0] act_v);
        assert (exp_v === act_v) else begin
            $display("FAIL %s %s expected %h actual %h", test, field, exp_v, act_v);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // --------------------
    // page table image
    // --------------------
    function automatic pte_t make_pte(input ppn_t ppn, input logic [7:0] flags);
        return {10'b0, ppn, 2'b0, flags};
    endfunction

    function automatic vaddr_t make_va(input int v2, input int v1, input int v0);
        return {9'(v2), 9'(v1), 9'(v0), 12'habc};
    endfunction

    function automatic pte_t read_image(input paddr_t addr);
        if (mem0.img.exists(addr)) begin
            return mem0.img[addr];
        end
        return '0;
    endfunction

    task automatic put_pte(input ppn_t table_ppn, input int idx, input pte_t pte);
        mem0.img[{table_ppn, 12'h0} + paddr_t'(idx * 8)] = pte;
    endtask

    // flags: V=01 R=02 W=04 X=08 G=20 A=40 D=80
    task automatic build_table();
        // root at 0x80000
        put_pte(44'h80000, 1, make_pte(44'h81000, 8'h01));
        put_pte(44'h80000, 2, make_pte(44'h83000, 8'h21));
        put_pte(44'h80000, 3, make_pte(44'h40000, 8'he7));
        put_pte(44'h80000, 4, make_pte(44'h40200, 8'hc7));
        // level 2 tables
        put_pte(44'h81000, 0, make_pte(44'h82000, 8'h01));
        put_pte(44'h81000, 1, make_pte(44'h00200, 8'hcf));
        put_pte(44'h83000, 0, make_pte(44'h00400, 8'hc7));
        put_pte(44'h83000, 1, make_pte(44'h00401, 8'hc7));
        // level 3 table, index 1 left empty
        put_pte(44'h82000, 0, make_pte(44'h12345, 8'hcf));
        put_pte(44'h82000, 2, make_pte(44'h12346, 8'h45));
        put_pte(44'h82000, 3, make_pte(44'h12347, 8'hc3));
        put_pte(44'h82000, 4, make_pte(44'h12348, 8'h43));
        put_pte(44'h82000, 5, make_pte(44'h12349, 8'h49));
        put_pte(44'h82000, 6, make_pte(44'h1234a, 8'h01));
        put_pte(44'h82000, 7, make_pte(44'h1234b, 8'h47));
    endtask

    // --------------------
    // reference walk
    // --------------------
    task automatic ref_walk(input vaddr_t va, input logic instr, input logic store,
                            input logic mxr_v, output logic fault,
                            output walk_lvl_e lvl, output pte_t content);
        ppn_t       ppn;
        pte_t       pte;
        paddr_t     addr;
        logic [8:0] seg;
        logic       g_any;
        logic       done;
        logic       v, r, w, x, a, d;
        ppn   = satp_ppn;
        g_any = 1'b0;
        done  = 1'b0;
        fault = 1'b0;
        lvl   = LVL1;
        content = '0;
        exp_addrs.delete();
        for (int i = 0; i < 3 && !done; i++) begin
            seg = 9'(va >> (12 + 9 * (2 - i)));
            // pointer is PPN times 4096 plus the VPN field times 8
            addr = {ppn, 12'h0} + paddr_t'({seg, 3'b0});
            exp_addrs.push_back(addr);
            pte = read_image(addr);
            lvl = walk_lvl_e'(i[1:0]);
            g_any = g_any | pte[`PTW_G_BIT];
            v = pte[0];
            r = pte[1];
            w = pte[2];
            x = pte[3];
            a = pte[6];
            d = pte[7];
            if (!v || (!r && w)) begin
                fault = 1'b1;
                done  = 1'b1;
            end else if (!r && !x) begin
                fault = (i == 2);
                done  = (i == 2);
                ppn   = pte[`PTW_PPN_LSB +: `PTW_PPNW];
            end else begin
                done = 1'b1;
                if (instr) begin
                    fault = !(x && a);
                end else begin
                    fault = !(a && (r || (x && mxr_v))) || (store && !(w && d));
                end
                // superpages must be aligned to their size
                if (i == 0 && pte[`PTW_PPN_LSB +: 18] != 18'h0) fault = 1'b1;
                if (i == 1 && pte[`PTW_PPN_LSB +: 9] != 9'h0) fault = 1'b1;
                content = pte;
                content[`PTW_G_BIT] = g_any;
            end
        end
    endtask

    // --------------------
    // stimulus
    // --------------------
    task automatic start_miss(input string name, input logic instr, input logic both,
                              input vaddr_t va);
        @(negedge clk_i);
        if (instr || both) begin
            itlb_access = 1'b1;
            // the losing ITLB asks for another page
            itlb_vaddr  = instr ? va : ~va;
        end
        if (!instr) begin
            dtlb_access = 1'b1;
            dtlb_vaddr  = va;
        end
        #1;
        // only the winning TLB reports a miss
        check_value(name, "itlb_miss_o", 64'(instr), 64'(itlb_miss_o));
        check_value(name, "dtlb_miss_o", 64'(!instr), 64'(dtlb_miss_o));
        @(negedge clk_i);
        itlb_access = 1'b0;
        dtlb_access = 1'b0;
    endtask

    task automatic run_walk(input string name, input logic instr, input logic both,
                            input vaddr_t va, input logic store, input logic mxr_v);
        logic      exp_fault;
        walk_lvl_e exp_lvl;
        pte_t      exp_content;
        int        updates;
        int        errors;
        logic      prev_req;
        ref_walk(va, instr, store, mxr_v, exp_fault, exp_lvl, exp_content);
        lsu_is_store = store;
        mxr = mxr_v;
        start_miss(name, instr, both, va);
        updates  = 0;
        errors   = 0;
        prev_req = 1'b0;
        while (ptw_active_o) begin
            // each new request must point at the next PTE of the reference walk
            if (mem_req_o && !prev_req) begin
                if (exp_addrs.size() == 0) begin
                    $display("%s issued more memory reads than the walk needs", name);
                    $display("Simulation failed");
                    $fatal(1, "unexpected memory read");
                end else begin
                    check_value(name, "mem_addr_o", 64'(exp_addrs[0]), 64'(mem_addr_o));
                    void'(exp_addrs.pop_front());
                end
            end
            prev_req = mem_req_o;
            if (itlb_update_valid_o || dtlb_update_valid_o) begin
                updates++;
                check_value(name, "itlb_update", 64'(instr), 64'(itlb_update_valid_o));
                check_value(name, "dtlb_update", 64'(!instr), 64'(dtlb_update_valid_o));
                check_value(name, "walking_instr_o", 64'(instr), 64'(walking_instr_o));
                check_value(name, "update_vpn_o", 64'(va[38:12]), 64'(update_vpn_o));
                check_value(name, "update_vaddr_o", 64'(va), 64'(update_vaddr_o));
                check_value(name, "update_asid_o", 64'(asid), 64'(update_asid_o));
                check_value(name, "update_content_o", exp_content, update_content_o);
                check_value(name, "update_is_1g_o", 64'(exp_lvl == LVL1), 64'(update_is_1g_o));
                check_value(name, "update_is_2m_o", 64'(exp_lvl == LVL2), 64'(update_is_2m_o));
            end
            if (ptw_error_o) errors++;
            @(negedge clk_i);
        end
        check_value(name, "reads not issued", 64'(0), 64'(exp_addrs.size()));
        check_value(name, "update pulses", 64'(!exp_fault), 64'(updates));
        check_value(name, "error pulses", 64'(exp_fault), 64'(errors));
    endtask

    // flush after a few cycles, before the three levels can finish
    task automatic flush_walk(input string name, input vaddr_t va);
        int delay;
        delay = int'($urandom % 7);
        start_miss(name, 1'b1, 1'b0, va);
        repeat (delay) begin
            check_value(name, "update", 64'(0), 64'(itlb_update_valid_o | dtlb_update_valid_o));
            check_value(name, "ptw_error_o", 64'(0), 64'(ptw_error_o));
            @(negedge clk_i);
        end
        flush_i = 1'b1;
        #1;
        check_value(name, "update", 64'(0), 64'(itlb_update_valid_o | dtlb_update_valid_o));
        check_value(name, "ptw_error_o", 64'(0), 64'(ptw_error_o));
        @(negedge clk_i);
        flush_i = 1'b0;
        // an owed read keeps the walker busy until it is absorbed
        while (ptw_active_o) begin
            check_value(name, "update", 64'(0), 64'(itlb_update_valid_o | dtlb_update_valid_o));
            check_value(name, "ptw_error_o", 64'(0), 64'(ptw_error_o));
            @(negedge clk_i);
        end
    endtask

    initial begin
        void'($urandom(36763));
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        flush_i      = 1'b0;
        en_instr     = 1'b1;
        en_data      = 1'b1;
        lsu_is_store = 1'b0;
        mxr          = 1'b0;
        asid         = 16'h5a5a;
        satp_ppn     = 44'h80000;
        itlb_access  = 1'b0;
        itlb_hit     = 1'b0;
        itlb_vaddr   = '0;
        dtlb_access  = 1'b0;
        dtlb_hit     = 1'b0;
        dtlb_vaddr   = '0;
        build_table();
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        check_value("reset", "outputs", 64'(0),
                    64'({mem_req_o, ptw_active_o, ptw_error_o, itlb_update_valid_o,
                         dtlb_update_valid_o, itlb_miss_o, dtlb_miss_o}));

        run_walk("itlb_4k", 1'b1, 1'b0, make_va(1, 0, 0), 1'b0, 1'b0);
        run_walk("dtlb_1g", 1'b0, 1'b0, make_va(3, 5, 7), 1'b0, 1'b0);
        run_walk("dtlb_2m_global", 1'b0, 1'b0, make_va(2, 0, 3), 1'b1, 1'b0);
        run_walk("dtlb_2m", 1'b0, 1'b0, make_va(1, 1, 9), 1'b0, 1'b0);
        run_walk("invalid_pte", 1'b1, 1'b0, make_va(1, 0, 1), 1'b0, 1'b0);
        run_walk("w_without_r", 1'b0, 1'b0, make_va(1, 0, 2), 1'b0, 1'b0);
        run_walk("no_exec", 1'b1, 1'b0, make_va(1, 0, 3), 1'b0, 1'b0);
        run_walk("store_read_only", 1'b0, 1'b0, make_va(1, 0, 4), 1'b1, 1'b0);
        run_walk("store_clean", 1'b0, 1'b0, make_va(1, 0, 7), 1'b1, 1'b0);
        run_walk("misaligned_1g", 1'b0, 1'b0, make_va(4, 0, 0), 1'b0, 1'b0);
        run_walk("misaligned_2m", 1'b0, 1'b0, make_va(2, 1, 0), 1'b0, 1'b0);
        run_walk("pointer_lvl3", 1'b0, 1'b0, make_va(1, 0, 6), 1'b0, 1'b0);
        run_walk("exec_only_load", 1'b0, 1'b0, make_va(1, 0, 5), 1'b0, 1'b0);
        run_walk("exec_only_mxr", 1'b0, 1'b0, make_va(1, 0, 5), 1'b0, 1'b1);
        run_walk("both_miss", 1'b0, 1'b1, make_va(1, 0, 0), 1'b0, 1'b0);
        flush_walk("flush", make_va(1, 0, 0));
        run_walk("after_flush", 1'b1, 1'b0, make_va(1, 0, 0), 1'b0, 1'b0);

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== bench/ptw_mem_model.sv ====
`timescale 1ns/1ns
`include "ptw_params.svh"

module ptw_mem_model (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            req_i,
    input  ptw_pkg::paddr_t addr_i,
    output logic            gnt_o,
    output logic            rvalid_o,
    output ptw_pkg::pte_t   rdata_o
);
    import ptw_pkg::*;

    // page table image, indexed by the byte address of each PTE
    pte_t   img [paddr_t];
    // cycles left before the next grant
    int     gnt_wait;
    // cycles left before the owed rvalid
    int     lat_cnt;
    paddr_t raddr;

    // outputs change on the falling edge, the walker samples on the rising one
    always @(negedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gnt_o    <= 1'b0;
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
            gnt_wait = 0;
            lat_cnt  = 0;
            raddr    = '0;
        end else begin
            gnt_o    <= 1'b0;
            rvalid_o <= 1'b0;
            // return the read data once the latency has run out
            if (lat_cnt > 0) begin
                lat_cnt = lat_cnt - 1;
                if (lat_cnt == 0) begin
                    rvalid_o <= 1'b1;
                    rdata_o  <= img.exists(raddr) ? img[raddr] : '0;
                end
            end
            // grant after a random wait, then pick the read latency
            if (req_i) begin
                if (gnt_wait == 0) begin
                    gnt_o    <= 1'b1;
                    raddr    = addr_i;
                    lat_cnt  = 1 + int'($urandom % 3);
                    gnt_wait = int'($urandom % 4);
                end else begin
                    gnt_wait = gnt_wait - 1;
                end
            end
        end
    end

endmodule

// ==== hw/ptw_top.sv ====
`timescale 1ns/1ns

module ptw_top (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             enable_translation_i,
    input  logic             en_ld_st_translation_i,
    input  logic             lsu_is_store_i,
    input  logic             mxr_i,
    input  ptw_pkg::asid_t   asid_i,
    input  ptw_pkg::ppn_t    satp_ppn_i,
    input  logic             itlb_access_i,
    input  logic             itlb_hit_i,
    input  ptw_pkg::vaddr_t  itlb_vaddr_i,
    input  logic             dtlb_access_i,
    input  logic             dtlb_hit_i,
    input  ptw_pkg::vaddr_t  dtlb_vaddr_i,
    input  logic             mem_gnt_i,
    input  logic             mem_rvalid_i,
    input  ptw_pkg::pte_t    mem_rdata_i,
    output logic             mem_req_o,
    output ptw_pkg::paddr_t  mem_addr_o,
    output logic             ptw_active_o,
    output logic             walking_instr_o,
    output logic             ptw_error_o,
    output logic             itlb_update_valid_o,
    output logic             dtlb_update_valid_o,
    output ptw_pkg::vpn_t    update_vpn_o,
    output ptw_pkg::asid_t   update_asid_o,
    output logic             update_is_2m_o,
    output logic             update_is_1g_o,
    output ptw_pkg::pte_t    update_content_o,
    output ptw_pkg::vaddr_t  update_vaddr_o,
    output logic             itlb_miss_o,
    output logic             dtlb_miss_o
);
    import ptw_pkg::*;

    // controller to context and checker
    logic      walk_start;
    logic      start_is_instr;
    vaddr_t    start_vaddr;
    logic      leaf_commit;
    walk_lvl_e lvl;
    pte_t      pte_q;
    logic      pte_valid_q;
    // checker verdict on the registered PTE
    logic      pte_fault;
    logic      pte_is_leaf;
    logic      pte_is_global;
    // walk context fed back
    logic      is_instr;
    vaddr_t    vaddr;

    ptw_walk_ctrl u_walk_ctrl (
        .clk_i                  (clk_i),
        .rst_ni                 (rst_ni),
        .flush_i                (flush_i),
        .enable_translation_i   (enable_translation_i),
        .en_ld_st_translation_i (en_ld_st_translation_i),
        .itlb_access_i          (itlb_access_i),
        .itlb_hit_i             (itlb_hit_i),
        .itlb_vaddr_i           (itlb_vaddr_i),
        .dtlb_access_i          (dtlb_access_i),
        .dtlb_hit_i             (dtlb_hit_i),
        .dtlb_vaddr_i           (dtlb_vaddr_i),
        .satp_ppn_i             (satp_ppn_i),
        .mem_gnt_i              (mem_gnt_i),
        .mem_rvalid_i           (mem_rvalid_i),
        .mem_rdata_i            (mem_rdata_i),
        .pte_fault_i            (pte_fault),
        .pte_is_leaf_i          (pte_is_leaf),
        .ctx_vaddr_i            (vaddr),
        .ctx_is_instr_i         (is_instr),
        .mem_req_o              (mem_req_o),
        .mem_addr_o             (mem_addr_o),
        .ptw_active_o           (ptw_active_o),
        .ptw_error_o            (ptw_error_o),
        .walk_start_o           (walk_start),
        .start_is_instr_o       (start_is_instr),
        .start_vaddr_o          (start_vaddr),
        .leaf_commit_o          (leaf_commit),
        .lvl_o                  (lvl),
        .pte_q_o                (pte_q),
        .pte_valid_q_o          (pte_valid_q),
        .itlb_miss_o            (itlb_miss_o),
        .dtlb_miss_o            (dtlb_miss_o)
    );

    ptw_pte_check u_pte_check (
        .pte_i           (pte_q),
        .lvl_i           (lvl),
        .is_instr_i      (is_instr),
        .is_store_i      (lsu_is_store_i),
        .mxr_i           (mxr_i),
        .pte_fault_o     (pte_fault),
        .pte_is_leaf_o   (pte_is_leaf),
        .pte_is_global_o (pte_is_global)
    );

    ptw_req_ctx u_req_ctx (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .walk_start_i        (walk_start),
        .start_is_instr_i    (start_is_instr),
        .start_vaddr_i       (start_vaddr),
        .asid_i              (asid_i),
        .pte_valid_q_i       (pte_valid_q),
        .pte_is_global_i     (pte_is_global),
        .leaf_commit_i       (leaf_commit),
        .lvl_i               (lvl),
        .pte_i               (pte_q),
        .is_instr_o          (is_instr),
        .vaddr_o             (vaddr),
        .walking_instr_o     (walking_instr_o),
        .itlb_update_valid_o (itlb_update_valid_o),
        .dtlb_update_valid_o (dtlb_update_valid_o),
        .update_vpn_o        (update_vpn_o),
        .update_asid_o       (update_asid_o),
        .update_is_2m_o      (update_is_2m_o),
        .update_is_1g_o      (update_is_1g_o),
        .update_content_o    (update_content_o),
        .update_vaddr_o      (update_vaddr_o)
    );

endmodule

// ==== hw/ptw_walk_ctrl.sv ====
`timescale 1ns/1ns
`include "ptw_params.svh"

module ptw_walk_ctrl (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  logic               enable_translation_i,
    input  logic               en_ld_st_translation_i,
    input  logic               itlb_access_i,
    input  logic               itlb_hit_i,
    input  ptw_pkg::vaddr_t    itlb_vaddr_i,
    input  logic               dtlb_access_i,
    input  logic               dtlb_hit_i,
    input  ptw_pkg::vaddr_t    dtlb_vaddr_i,
    input  ptw_pkg::ppn_t      satp_ppn_i,
    input  logic               mem_gnt_i,
    input  logic               mem_rvalid_i,
    input  ptw_pkg::pte_t      mem_rdata_i,
    input  logic               pte_fault_i,
    input  logic               pte_is_leaf_i,
    input  ptw_pkg::vaddr_t    ctx_vaddr_i,
    input  logic               ctx_is_instr_i,
    output logic               mem_req_o,
    output ptw_pkg::paddr_t    mem_addr_o,
    output logic               ptw_active_o,
    output logic               ptw_error_o,
    output logic               walk_start_o,
    output logic               start_is_instr_o,
    output ptw_pkg::vaddr_t    start_vaddr_o,
    output logic               leaf_commit_o,
    output ptw_pkg::walk_lvl_e lvl_o,
    output ptw_pkg::pte_t      pte_q_o,
    output logic               pte_valid_q_o,
    output logic               itlb_miss_o,
    output logic               dtlb_miss_o
);
    import ptw_pkg::*;

    walk_state_e state_q, state_d;
    walk_lvl_e   lvl_q, lvl_d;
    paddr_t      pptr_q, pptr_d;
    // registered read response
    logic        rvalid_q;
    pte_t        rdata_q;
    logic        itlb_miss;
    logic        dtlb_miss;
    logic        still_enabled;
    logic        read_owed;
    ppn_t        pte_ppn;

    // --------------------
    // miss arbitration
    // --------------------
    // the ITLB only wins when the LSU has no access pending
    assign itlb_miss = enable_translation_i & itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;
    assign dtlb_miss = en_ld_st_translation_i & dtlb_access_i & ~dtlb_hit_i;

    // a miss is only taken in IDLE and never together with a flush
    assign itlb_miss_o      = (state_q == IDLE) & ~flush_i & itlb_miss;
    assign dtlb_miss_o      = (state_q == IDLE) & ~flush_i & ~itlb_miss & dtlb_miss;
    assign walk_start_o     = itlb_miss_o | dtlb_miss_o;
    assign start_is_instr_o = itlb_miss;
    assign start_vaddr_o    = itlb_miss ? itlb_vaddr_i : dtlb_vaddr_i;

    // translation for the walking side must still be on to commit a leaf
    assign still_enabled = ctx_is_instr_i ? enable_translation_i : en_ld_st_translation_i;

    // next table base comes from the PPN of the fetched pointer
    assign pte_ppn = rdata_q[`PTW_PPN_LSB +: `PTW_PPNW];

    // a granted read whose rvalid has not been registered yet
    assign read_owed = ((state_q == WAIT_GRANT) && mem_gnt_i)
                    || ((state_q == PTE_LOOKUP) && !rvalid_q)
                    || ((state_q == WAIT_RVALID) && !rvalid_q);

    // --------------------
    // walk FSM
    // --------------------
    always_comb begin
        state_d       = state_q;
        lvl_d         = lvl_q;
        pptr_d        = pptr_q;
        leaf_commit_o = 1'b0;

        case (state_q)
            IDLE: begin
                // every walk begins at the 1 GiB level
                lvl_d = LVL1;
                if (walk_start_o) begin
                    // root table from satp, indexed by VPN[2]
                    pptr_d  = {satp_ppn_i,
                               start_vaddr_o[`PTW_PAGE_OFS_W + 2*`PTW_VPN_SEG_W +: `PTW_VPN_SEG_W],
                               {`PTW_PTE_OFS_W{1'b0}}};
                    state_d = WAIT_GRANT;
                end
            end

            WAIT_GRANT: begin
                if (mem_gnt_i) begin
                    state_d = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                // judge the PTE in the cycle after rvalid
                if (rvalid_q) begin
                    if (pte_fault_i) begin
                        state_d = PROPAGATE_ERROR;
                    end else if (pte_is_leaf_i) begin
                        state_d       = IDLE;
                        leaf_commit_o = still_enabled & ~flush_i;
                    end else begin
                        state_d = WAIT_GRANT;
                        case (lvl_q)
                            LVL1: begin
                                lvl_d  = LVL2;
                                pptr_d = {pte_ppn,
                                          ctx_vaddr_i[`PTW_PAGE_OFS_W + `PTW_VPN_SEG_W +:
                                                      `PTW_VPN_SEG_W],
                                          {`PTW_PTE_OFS_W{1'b0}}};
                            end
                            LVL2: begin
                                lvl_d  = LVL3;
                                pptr_d = {pte_ppn,
                                          ctx_vaddr_i[`PTW_PAGE_OFS_W +: `PTW_VPN_SEG_W],
                                          {`PTW_PTE_OFS_W{1'b0}}};
                            end
                            // no level below LVL3 to point to
                            default: state_d = PROPAGATE_ERROR;
                        endcase
                    end
                end
            end

            PROPAGATE_ERROR: begin
                state_d = IDLE;
            end

            // absorb the read left over from a flushed walk
            WAIT_RVALID: begin
                if (rvalid_q) begin
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // flush wins over everything, but an owed read must still come back
        if (flush_i) begin
            state_d = read_owed ? WAIT_RVALID : IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            lvl_q    <= LVL1;
            pptr_q   <= '0;
            rvalid_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            lvl_q    <= lvl_d;
            pptr_q   <= pptr_d;
            rvalid_q <= mem_rvalid_i;
        end
    end

    // read data is only looked at together with rvalid_q
    always_ff @(posedge clk_i) begin
        rdata_q <= mem_rdata_i;
    end

    assign mem_req_o     = (state_q == WAIT_GRANT);
    assign mem_addr_o    = pptr_q;
    assign ptw_active_o  = (state_q != IDLE);
    assign ptw_error_o   = (state_q == PROPAGATE_ERROR) & ~flush_i;
    assign lvl_o         = lvl_q;
    assign pte_q_o       = rdata_q;
    assign pte_valid_q_o = rvalid_q;

endmodule

// ==== hw/ptw_req_ctx.sv ====
`timescale 1ns/1ns
`include "ptw_params.svh"

module ptw_req_ctx (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               walk_start_i,
    input  logic               start_is_instr_i,
    input  ptw_pkg::vaddr_t    start_vaddr_i,
    input  ptw_pkg::asid_t     asid_i,
    input  logic               pte_valid_q_i,
    input  logic               pte_is_global_i,
    input  logic               leaf_commit_i,
    input  ptw_pkg::walk_lvl_e lvl_i,
    input  ptw_pkg::pte_t      pte_i,
    output logic               is_instr_o,
    output ptw_pkg::vaddr_t    vaddr_o,
    output logic               walking_instr_o,
    output logic               itlb_update_valid_o,
    output logic               dtlb_update_valid_o,
    output ptw_pkg::vpn_t      update_vpn_o,
    output ptw_pkg::asid_t     update_asid_o,
    output logic               update_is_2m_o,
    output logic               update_is_1g_o,
    output ptw_pkg::pte_t      update_content_o,
    output ptw_pkg::vaddr_t    update_vaddr_o
);
    import ptw_pkg::*;

    logic   is_instr_q;
    // G seen on any level so far
    logic   global_q;
    vaddr_t vaddr_q;
    asid_t  asid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            is_instr_q <= 1'b0;
            global_q   <= 1'b0;
        end else if (walk_start_i) begin
            is_instr_q <= start_is_instr_i;
            global_q   <= 1'b0;
        end else if (pte_valid_q_i && pte_is_global_i) begin
            // sticky until the next walk starts
            global_q   <= 1'b1;
        end
    end

    // miss context, captured once per walk
    always_ff @(posedge clk_i) begin
        if (walk_start_i) begin
            vaddr_q <= start_vaddr_i;
            asid_q  <= asid_i;
        end
    end

    assign is_instr_o      = is_instr_q;
    assign vaddr_o         = vaddr_q;
    assign walking_instr_o = is_instr_q;

    // --------------------
    // TLB update entry
    // --------------------
    // the pulse goes only to the TLB that missed
    assign itlb_update_valid_o = leaf_commit_i & is_instr_q;
    assign dtlb_update_valid_o = leaf_commit_i & ~is_instr_q;

    assign update_vpn_o   = vaddr_q[`PTW_PAGE_OFS_W +: `PTW_VPN_W];
    assign update_asid_o  = asid_q;
    assign update_vaddr_o = vaddr_q;
    // leaf level gives the page size
    assign update_is_2m_o = (lvl_i == LVL2);
    assign update_is_1g_o = (lvl_i == LVL1);

    // leaf PTE with G inherited from upper levels
    always_comb begin
        update_content_o               = pte_i;
        update_content_o[`PTW_G_BIT]   = pte_i[`PTW_G_BIT] | global_q;
    end

endmodule

// ==== hw/ptw_pte_check.sv ====
`timescale 1ns/1ns
`include "ptw_params.svh"

module ptw_pte_check (
    input  ptw_pkg::pte_t      pte_i,
    input  ptw_pkg::walk_lvl_e lvl_i,
    input  logic               is_instr_i,
    input  logic               is_store_i,
    input  logic               mxr_i,
    output logic               pte_fault_o,
    output logic               pte_is_leaf_o,
    output logic               pte_is_global_o
);
    import ptw_pkg::*;

    logic v, r, w, x, a, d;
    ppn_t ppn;

    // field split of the PTE
    assign v   = pte_i[`PTW_V_BIT];
    assign r   = pte_i[`PTW_R_BIT];
    assign w   = pte_i[`PTW_W_BIT];
    assign x   = pte_i[`PTW_X_BIT];
    assign a   = pte_i[`PTW_A_BIT];
    assign d   = pte_i[`PTW_D_BIT];
    assign ppn = pte_i[`PTW_PPN_LSB +: `PTW_PPNW];

    // any of R or X makes it a leaf, otherwise a pointer
    assign pte_is_leaf_o   = r | x;
    assign pte_is_global_o = pte_i[`PTW_G_BIT];

    always_comb begin
        pte_fault_o = 1'b0;
        // reserved encodings, W without R is illegal
        if (!v || (!r && w)) begin
            pte_fault_o = 1'b1;
        end else if (!(r || x)) begin
            // pointer at the last level has nowhere to go
            pte_fault_o = (lvl_i == LVL3);
        end else begin
            if (is_instr_i) begin
                // fetch needs X, A is managed by software
                pte_fault_o = !x || !a;
            end else begin
                // loads need R, or X when MXR is set
                pte_fault_o = !a || !(r || (x && mxr_i));
                // stores also need a writable, dirty page
                if (is_store_i && (!w || !d)) begin
                    pte_fault_o = 1'b1;
                end
            end
            // superpage PPN must be aligned to its size
            if (lvl_i == LVL1 && ppn[2*`PTW_VPN_SEG_W-1:0] != '0) begin
                pte_fault_o = 1'b1;
            end
            if (lvl_i == LVL2 && ppn[`PTW_VPN_SEG_W-1:0] != '0) begin
                pte_fault_o = 1'b1;
            end
        end
    end

endmodule

// ==== hw/ptw_pkg.sv ====
`include "ptw_params.svh"

package ptw_pkg;

    // --------------------
    // address and entry vectors
    // --------------------

    // virtual address as seen by the TLBs
    typedef logic [`PTW_VLEN-1:0]   vaddr_t;
    // byte pointer to a PTE in memory
    typedef logic [`PTW_PLEN-1:0]   paddr_t;
    // physical page number, from satp or from a PTE
    typedef logic [`PTW_PPNW-1:0]   ppn_t;
    typedef logic [`PTW_ASID_W-1:0] asid_t;
    // raw PTE, also the width of one memory word
    typedef logic [`PTW_PTE_W-1:0]  pte_t;
    // the three VPN fields of a virtual address
    typedef logic [`PTW_VPN_W-1:0]  vpn_t;

    // --------------------
    // state machines
    // --------------------

    // walk controller states
    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } walk_state_e;

    // table level, LVL1 maps 1 GiB pages
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } walk_lvl_e;

endpackage

// ==== include/ptw_params.svh ====
`ifndef PTW_PARAMS_SVH
`define PTW_PARAMS_SVH

// Sv39 address and entry widths
`define PTW_VLEN        39
`define PTW_PLEN        56
`define PTW_PPNW        44
`define PTW_ASID_W      16
`define PTW_PTE_W       64
`define PTW_VPN_W       27
`define PTW_VPN_SEG_W   9
`define PTW_PAGE_OFS_W  12
`define PTW_PTE_OFS_W   3

// bit positions inside a PTE
`define PTW_V_BIT       0
`define PTW_R_BIT       1
`define PTW_W_BIT       2
`define PTW_X_BIT       3
`define PTW_U_BIT       4
`define PTW_G_BIT       5
`define PTW_A_BIT       6
`define PTW_D_BIT       7
`define PTW_PPN_LSB     10

`endif
